// ==== build.f ====
+incdir+rtl
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/issueQueue.sv
rtl/ctrl.sv
rtl/alu.sv
rtl/mdu.sv
rtl/branchUnit.sv
rtl/exCore.sv
sim/exCore_assert.sv
sim/exCore_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the exCore testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module exCore_tb -f build.f -o simv \
	> build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/simv > sim.log 2>&1

grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== sim/exCore_tb.sv ====
`include "cpu_defines.svh"

module exCore_tb;
	import isaPkg::*;
	import pipePkg::*;

	localparam int numInstr = 300;

	localparam functT  aluFns [6] = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT, `FN_SLTU};
	localparam opcodeT immOps [4] = '{`OP_ORI, `OP_ADDI, `OP_ANDI, `OP_LUI};
	localparam functT  mduFns [4] = '{`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU};
	// lw sw lb lh sb sh and two opcodes with no decode
	localparam opcodeT badOps [8] = '{6'h23, 6'h2b, 6'h20, 6'h21, 6'h28, 6'h29, 6'h3f, 6'h10};

	string kindNames [9] = '{"aluReg", "aluImm", "branch", "jump", "jr", "mduStart",
		"mduRead", "mduWrite", "illegal"};

	logic   clk;
	logic   rstN;
	logic   inValid;
	issueT  inPkt;
	logic   inCredit;
	logic   outValid;
	retireT outRec;
	logic   outCreditRet;

	retireT sbQ [$];     // Expected records in program order
	string  nameQ [$];
	wordT   modelHi, modelLo;
	int     upCredits, pendRet, holdLeft, sent, retired;

	exCore i_exCore (.clk, .rstN, .inValid, .inPkt, .inCredit, .outValid, .outRec,
		.outCreditRet);

	always #5 clk = ~clk;

	////////////////////
	// Stimulus
	function automatic issueT randInstr(output int kind);
		issueT  p;
		regIdxT rs, rt, rd;
		logic [15:0] imm;
		rs      = regIdxT'($urandom);
		rt      = regIdxT'($urandom);
		rd      = regIdxT'($urandom);
		imm     = 16'($urandom);
		p.pc    = $urandom & 32'hffff_fffc;
		p.rsVal = $urandom;
		p.rtVal = $urandom;
		kind    = $urandom % 9;
		case (kind)
			0: p.instr = {`OP_RTYPE, rs, rt, rd, 5'b0, aluFns[$urandom % 6]};
			1: p.instr = {immOps[$urandom % 4], rs, rt, imm};
			2: begin
				p.instr = {($urandom % 2) ? `OP_BEQ : `OP_BNE, rs, rt, imm};
				if ($urandom % 2)
					p.rtVal = p.rsVal;   // Equal operands
			end
			3: p.instr = {($urandom % 2) ? `OP_J : `OP_JAL, 26'($urandom)};
			4: p.instr = {`OP_RTYPE, rs, 15'b0, `FN_JR};
			5: begin
				p.instr = {`OP_RTYPE, rs, rt, 10'b0, mduFns[$urandom % 4]};
				if ($urandom % 4 == 0)
					p.rtVal = '0;
				else if (p.rtVal == '1)
					p.rtVal = 32'd3;   // Keeps clear of the signed overflow case
			end
			6: p.instr = {`OP_RTYPE, 10'b0, rd, 5'b0, ($urandom % 2) ? `FN_MFHI : `FN_MFLO};
			7: p.instr = {`OP_RTYPE, rs, 15'b0, ($urandom % 2) ? `FN_MTHI : `FN_MTLO};
			default: p.instr = {badOps[$urandom % 8], rs, rt, imm};
		endcase
		return p;
	endfunction

	////////////////////
	// Reference model
	task automatic modelExec(input issueT p, output retireT r);
		opcodeT op;
		functT  fn;
		wordT   rs, rt, immS, val;
		addrT   pc4;
		regIdxT dst;
		logic   wr;
		op       = p.instr[31:26];
		fn       = p.instr[5:0];
		rs       = p.rsVal;
		rt       = p.rtVal;
		pc4      = p.pc + 32'd4;
		immS     = {{16{p.instr[15]}}, p.instr[15:0]};
		wr       = 1'b1;
		dst      = p.instr[15:11];   // rd
		val      = '0;
		r        = '0;
		r.pc     = p.pc;
		r.nextPc = pc4;
		case (op)
			`OP_RTYPE: begin
				wr = !(fn inside {`FN_JR, `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU, `FN_MTHI,
					`FN_MTLO});
				case (fn)
					`FN_ADD:   val = rs + rt;
					`FN_SUB:   val = rs - rt;
					`FN_AND:   val = rs & rt;
					`FN_OR:    val = rs | rt;
					`FN_SLT:   val = wordT'($signed(rs) < $signed(rt));
					`FN_SLTU:  val = wordT'(rs < rt);
					`FN_MFHI:  val = modelHi;
					`FN_MFLO:  val = modelLo;
					`FN_MTHI:  modelHi = rs;
					`FN_MTLO:  modelLo = rs;
					`FN_JR:    r.nextPc = rs;
					`FN_MULT:  {modelHi, modelLo} = longint'($signed(rs)) * longint'($signed(rt));
					`FN_MULTU: {modelHi, modelLo} = 64'(rs) * 64'(rt);
					`FN_DIV: begin
						if (rt != '0) begin   // Zero divisor keeps HI and LO
							modelLo = $signed(rs) / $signed(rt);
							modelHi = $signed(rs) % $signed(rt);
						end
					end
					`FN_DIVU: begin
						if (rt != '0) begin
							modelLo = rs / rt;
							modelHi = rs % rt;
						end
					end
					default: begin
						wr        = 1'b0;
						r.illegal = 1'b1;
					end
				endcase
			end
			`OP_ADDI: val = rs + immS;
			`OP_ORI:  val = rs | {16'b0, p.instr[15:0]};
			`OP_ANDI: val = rs & {16'b0, p.instr[15:0]};
			`OP_LUI:  val = {p.instr[15:0], 16'b0};
			`OP_BEQ, `OP_BNE: begin
				wr = 1'b0;
				if ((rs == rt) == (op == `OP_BEQ))
					r.nextPc = pc4 + (immS << 2);
			end
			`OP_J, `OP_JAL: begin
				wr       = (op == `OP_JAL);
				dst      = 5'd31;
				val      = p.pc + 32'd8;   // Return past the delay slot
				r.nextPc = {pc4[31:28], p.instr[25:0], 2'b00};
			end
			default: begin
				wr        = 1'b0;
				r.illegal = 1'b1;
			end
		endcase
		if (op inside {`OP_ADDI, `OP_ORI, `OP_ANDI, `OP_LUI})
			dst = p.instr[20:16];
		r.regWrite = wr;
		r.wAddr    = wr ? dst : '0;
		r.wData    = wr ? val : '0;
	endtask

	////////////////////
	// One clock cycle of monitor, credits and drive
	task automatic stepCycle();
		issueT  pkt;
		retireT rec, expRec;
		string  name;
		int     kind;
		@(posedge clk);
		#1;
		if (outValid) begin
			if (sbQ.size() == 0) begin
				$display("Record retired at pc %h with nothing outstanding", outRec.pc);
				$display("Simulation failed");
				$fatal(1);
			end else begin
				expRec = sbQ.pop_front();
				name   = nameQ.pop_front();
				retireMatch: assert (outRec == expRec)
					else begin
						$display("FAIL %s at pc %h: expected %h, actual %h", name, expRec.pc,
							expRec, outRec);
						$display("Simulation failed");
						$fatal(1);
					end
				retired++;
				pendRet++;
			end
		end
		if (inCredit)
			upCredits++;
		outCreditRet = 1'b0;
		if (holdLeft > 0)
			holdLeft--;
		else if ($urandom % 128 == 0)
			holdLeft = 20 + $urandom % 40;   // Long stretch with no credit back
		else if (pendRet > 0 && $urandom % 3 != 0) begin
			outCreditRet = 1'b1;
			pendRet--;
		end
		inValid = 1'b0;
		if (upCredits > 0 && sent < numInstr && $urandom % 4 != 0) begin
			pkt = randInstr(kind);
			modelExec(pkt, rec);
			sbQ.push_back(rec);
			nameQ.push_back(kindNames[kind]);
			inPkt   = pkt;
			inValid = 1'b1;
			upCredits--;
			sent++;
		end
	endtask

	initial begin
		void'($urandom(32'hf4459960));
		clk          = 1'b0;
		rstN         = 1'b0;
		inValid      = 1'b0;
		inPkt        = '0;
		outCreditRet = 1'b0;
		modelHi      = '0;
		modelLo      = '0;
		upCredits    = `IN_CREDITS;
		pendRet      = 0;
		holdLeft     = 60;   // Start with downstream stalled so the queue fills
		sent         = 0;
		retired      = 0;
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		while (retired < numInstr)
			stepCycle();
		repeat (10)
			stepCycle();   // Catch stray records
		$display("Simulation passed");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (numInstr * (`DIV_CYCLES + 10)) @(posedge clk);
		$display("Timeout after %0d of %0d records retired", retired, numInstr);
		$display("Simulation failed");
		$fatal(1);
	end

endmodule

// ==== sim/exCore_assert.sv ====
`include "cpu_defines.svh"

module exCore_assert (
	input logic clk,
	input logic rstN,
	input logic inValid,
	input logic inCredit,
	input logic pop,
	input logic outValid,
	input logic outCreditRet
);
	int occupancy;   // Packets held in the issue queue
	int outAvail;    // Retire credits downstream still grants

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			occupancy <= 0;
			outAvail  <= `OUT_CREDITS;
		end else begin
			occupancy <= occupancy + int'(inValid) - int'(pop);
			outAvail  <= outAvail - int'(outValid) + int'(outCreditRet);
		end
	end

	////////////////////
	// Protocol checks
	resetQuiet: assert property (@(posedge clk) !rstN |-> (!outValid && !inCredit))
		else $error("outValid or inCredit active during reset");

	creditBound: assert property (@(posedge clk) disable iff (!rstN)
		outValid |-> (outAvail > 0))
		else $error("outValid with no retire credit left");

	noOverflow: assert property (@(posedge clk) disable iff (!rstN)
		inValid |-> (occupancy < `IN_CREDITS))
		else $error("Push into a full issue queue");

endmodule

bind exCore exCore_assert i_exCoreAssert (.clk, .rstN, .inValid, .inCredit, .pop, .outValid,
	.outCreditRet);

// ==== rtl/exCore.sv ====
module exCore (
	input  logic            clk,
	input  logic            rstN,
	input  logic            inValid,
	input  pipePkg::issueT  inPkt,
	output logic            inCredit,
	output logic            outValid,
	output pipePkg::retireT outRec,
	input  logic            outCreditRet
);
	import isaPkg::*;
	import pipePkg::*;

	issueT head;
	logic  notEmpty, pop, mduBusy;
	aluOpE aluOp;
	wordT  aluA, aluB, aluY;
	mduOpE mduOp;
	wordT  mduA, mduB, hi, lo;
	npcOpE npcOp;
	addrT  nextPc, link;

	////////////////////
	// Issue side
	issueQueue i_issueQueue (.clk, .rstN, .push(inValid), .pushPkt(inPkt), .pop,
		.head, .notEmpty, .credit(inCredit));

	ctrl i_ctrl (.clk, .rstN, .head, .notEmpty, .pop, .mduBusy, .aluOp, .aluA, .aluB,
		.aluY, .mduOp, .mduA, .mduB, .hi, .lo, .npcOp, .nextPc, .link, .outCreditRet,
		.outValid, .outRec);

	////////////////////
	// Datapath units
	alu i_alu (.op(aluOp), .a(aluA), .b(aluB), .y(aluY));

	mdu i_mdu (.clk, .rstN, .op(mduOp), .a(mduA), .b(mduB), .busy(mduBusy), .hi, .lo);

	branchUnit i_branchUnit (
		.op(npcOp),
		.pc(head.pc),
		.instr(head.instr),
		.rsVal(head.rsVal),
		.rtVal(head.rtVal),
		.nextPc,
		.link
	);

endmodule

// ==== rtl/branchUnit.sv ====
module branchUnit (
	input  isaPkg::npcOpE op,
	input  isaPkg::addrT  pc,
	input  isaPkg::wordT  instr,
	input  isaPkg::wordT  rsVal,
	input  isaPkg::wordT  rtVal,
	output isaPkg::addrT  nextPc,
	output isaPkg::addrT  link
);
	import isaPkg::*;

	addrT pcPlus4;
	addrT brTarget;
	logic eq;

	assign pcPlus4  = pc + 32'd4;
	assign brTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign eq       = (rsVal == rtVal);
	assign link     = pc + 32'd8;   // Past the delay slot

	always_comb begin
		case (op)
			npcBeq:  nextPc = eq ? brTarget : pcPlus4;
			npcBne:  nextPc = eq ? pcPlus4 : brTarget;
			npcJump: nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
			npcJr:   nextPc = rsVal;
			default: nextPc = pcPlus4;
		endcase
	end

endmodule

// ==== rtl/mdu.sv ====
`include "cpu_defines.svh"

module mdu (
	input  logic          clk,
	input  logic          rstN,
	input  isaPkg::mduOpE op,
	input  isaPkg::wordT  a,
	input  isaPkg::wordT  b,
	output logic          busy,
	output isaPkg::wordT  hi,
	output isaPkg::wordT  lo
);
	import isaPkg::*;

	typedef logic [$clog2(`DIV_CYCLES+1)-1:0] cntT;

	cntT         cnt;
	mduOpE       curOp;
	wordT        opA, opB;
	wordT        quot, rem;
	logic        start, isMul;
	logic [63:0] prod;

	assign start = (op inside {mduMult, mduMultu, mduDiv, mduDivu});
	assign isMul = (curOp == mduMult) || (curOp == mduMultu);
	assign busy  = (cnt != '0);

	////////////////////
	// Result of the captured operands
	always_comb begin
		if (curOp == mduMult)
			prod = $signed({{32{opA[31]}}, opA}) * $signed({{32{opB[31]}}, opB});
		else
			prod = {32'b0, opA} * {32'b0, opB};
		if (opB == '0) begin
			quot = '0;
			rem  = '0;
		end else if (curOp == mduDiv) begin
			quot = $signed(opA) / $signed(opB);
			rem  = $signed(opA) % $signed(opB);   // Sign follows the dividend
		end else begin
			quot = opA / opB;
			rem  = opA % opB;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			opA <= a;
			opB <= b;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			cnt   <= '0;
			curOp <= mduNone;
			hi    <= '0;
			lo    <= '0;
		end else if (start) begin
			cnt   <= (op == mduMult || op == mduMultu) ? cntT'(`MULT_CYCLES)
			                                           : cntT'(`DIV_CYCLES);
			curOp <= op;
		end else if (busy) begin
			cnt <= cnt - 1'b1;
			if (cnt == cntT'(1)) begin   // Last busy cycle, HI/LO land as busy falls
				if (isMul)
					{hi, lo} <= prod;
				else if (opB != '0) begin
					hi <= rem;
					lo <= quot;
				end
			end
		end else if (op == mduMthi)
			hi <= a;
		else if (op == mduMtlo)
			lo <= a;
	end

endmodule

// ==== rtl/alu.sv ====
module alu (
	input  isaPkg::aluOpE op,
	input  isaPkg::wordT  a,
	input  isaPkg::wordT  b,
	output isaPkg::wordT  y
);
	import isaPkg::*;

	logic ltSigned, ltUnsigned;

	assign ltSigned   = ($signed(a) < $signed(b));
	assign ltUnsigned = (a < b);

	// No overflow trap on add/sub
	always_comb begin
		case (op)
			aluAdd:
				y = a + b;
			aluSub:
				y = a - b;
			aluAnd:
				y = a & b;
			aluOr:
				y = a | b;
			aluSlt:
				y = {31'b0, ltSigned};
			aluSltu:
				y = {31'b0, ltUnsigned};
			aluLui:
				y = {b[15:0], 16'b0};   // Immediate to the upper half
			default:
				y = '0;
		endcase
	end

endmodule

// ==== rtl/ctrl.sv ====
`include "cpu_defines.svh"

module ctrl (
	input  logic            clk,
	input  logic            rstN,
	input  pipePkg::issueT  head,
	input  logic            notEmpty,
	output logic            pop,
	input  logic            mduBusy,
	output isaPkg::aluOpE   aluOp,
	output isaPkg::wordT    aluA,
	output isaPkg::wordT    aluB,
	input  isaPkg::wordT    aluY,
	output isaPkg::mduOpE   mduOp,
	output isaPkg::wordT    mduA,
	output isaPkg::wordT    mduB,
	input  isaPkg::wordT    hi,
	input  isaPkg::wordT    lo,
	output isaPkg::npcOpE   npcOp,
	input  isaPkg::addrT    nextPc,
	input  isaPkg::addrT    link,
	input  logic            outCreditRet,
	output logic            outValid,
	output pipePkg::retireT outRec
);
	import isaPkg::*;
	import pipePkg::*;

	typedef logic [$clog2(`OUT_CREDITS+1)-1:0] creditT;

	typedef enum logic {
		stRun,
		stMduWait   // Head is an MDU op, unit still busy
	} stateE;

	stateE  state;
	ctrlT   dec;
	wordT   imm, result;
	logic   headMdu, creditOk, exValid;
	retireT exRec;
	creditT outCredits;

	////////////////////
	// Decode
	function automatic ctrlT decode(wordT instr);
		opcodeT op;
		functT  fn;
		ctrlT   c;
		op = instr[31:26];
		fn = instr[5:0];
		c = '{aluOp: aluAdd, aluSrcImm: 1'b0, extSigned: 1'b0, mduOp: mduNone,
			npcOp: npcSeq, resSel: resAlu, regWrite: 1'b0, regDst: instr[15:11],
			illegal: 1'b0};
		case (op)
			`OP_RTYPE: begin
				case (fn)
					`FN_ADD:   c.aluOp = aluAdd;
					`FN_SUB:   c.aluOp = aluSub;
					`FN_AND:   c.aluOp = aluAnd;
					`FN_OR:    c.aluOp = aluOr;
					`FN_SLT:   c.aluOp = aluSlt;
					`FN_SLTU:  c.aluOp = aluSltu;
					`FN_MFHI:  c.resSel = resHi;
					`FN_MFLO:  c.resSel = resLo;
					`FN_JR:    c.npcOp = npcJr;
					`FN_MULT:  c.mduOp = mduMult;
					`FN_MULTU: c.mduOp = mduMultu;
					`FN_DIV:   c.mduOp = mduDiv;
					`FN_DIVU:  c.mduOp = mduDivu;
					`FN_MTHI:  c.mduOp = mduMthi;
					`FN_MTLO:  c.mduOp = mduMtlo;
					default:   c.illegal = 1'b1;
				endcase
				c.regWrite = !(c.npcOp == npcJr || c.mduOp != mduNone || c.illegal);
			end
			`OP_ORI:  c.aluOp = aluOr;
			`OP_ANDI: c.aluOp = aluAnd;
			`OP_LUI:  c.aluOp = aluLui;
			`OP_ADDI: begin
				c.aluOp     = aluAdd;
				c.extSigned = 1'b1;
			end
			`OP_BEQ:  c.npcOp = npcBeq;
			`OP_BNE:  c.npcOp = npcBne;
			`OP_J:    c.npcOp = npcJump;
			`OP_JAL: begin
				c.npcOp    = npcJump;
				c.resSel   = resLink;
				c.regWrite = 1'b1;
				c.regDst   = 5'd31;
			end
			default:  c.illegal = 1'b1;   // Loads, stores, unknown
		endcase
		if (op inside {`OP_ORI, `OP_ANDI, `OP_ADDI, `OP_LUI}) begin
			c.aluSrcImm = 1'b1;
			c.regWrite  = 1'b1;
			c.regDst    = instr[20:16];   // rt
		end
		return c;
	endfunction

	assign dec  = decode(head.instr);
	assign imm  = dec.extSigned ? {{16{head.instr[15]}}, head.instr[15:0]}
	                            : {16'b0, head.instr[15:0]};
	assign aluOp = dec.aluOp;
	assign aluA  = head.rsVal;
	assign aluB  = dec.aluSrcImm ? imm : head.rtVal;
	assign mduOp = pop ? dec.mduOp : mduNone;   // Start only on the pop edge
	assign mduA  = head.rsVal;
	assign mduB  = head.rtVal;
	assign npcOp = dec.npcOp;

	always_comb begin
		case (dec.resSel)
			resHi:   result = hi;
			resLo:   result = lo;
			resLink: result = link;
			default: result = aluY;
		endcase
	end

	////////////////////
	// Issue and credits
	assign headMdu  = (dec.mduOp != mduNone) || (dec.resSel inside {resHi, resLo});
	assign creditOk = (outCredits > creditT'(exValid));   // Record in flight holds one

	always_comb begin
		case (state)
			stMduWait: pop = creditOk && !mduBusy;
			default:   pop = notEmpty && creditOk && !(headMdu && mduBusy);
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state      <= stRun;
			exValid    <= 1'b0;
			outValid   <= 1'b0;
			outCredits <= creditT'(`OUT_CREDITS);
		end else begin
			if (state == stRun && notEmpty && headMdu && mduBusy)
				state <= stMduWait;
			else if (state == stMduWait && pop)
				state <= stRun;
			exValid    <= pop;
			outValid   <= exValid;
			outCredits <= outCredits - creditT'(exValid) + creditT'(outCreditRet);
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			exRec <= '{pc: head.pc, nextPc: nextPc, regWrite: dec.regWrite,
				wAddr: dec.regWrite ? dec.regDst : '0,
				wData: dec.regWrite ? result : '0, illegal: dec.illegal};
		end
		if (exValid)
			outRec <= exRec;
	end

endmodule

// ==== rtl/issueQueue.sv ====
`include "cpu_defines.svh"

module issueQueue (
	input  logic           clk,
	input  logic           rstN,
	input  logic           push,
	input  pipePkg::issueT pushPkt,
	input  logic           pop,
	output pipePkg::issueT head,
	output logic           notEmpty,
	output logic           credit
);
	import pipePkg::*;

	typedef logic [$clog2(`IN_CREDITS)-1:0]   ptrT;
	typedef logic [$clog2(`IN_CREDITS+1)-1:0] cntT;

	issueT mem [`IN_CREDITS];
	ptrT   wrPtr, rdPtr;
	cntT   count;

	function automatic ptrT nextPtr(ptrT p);
		return (p == ptrT'(`IN_CREDITS - 1)) ? '0 : p + 1'b1;   // Wrap at depth
	endfunction

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= pushPkt;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr  <= '0;
			rdPtr  <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			count  <= count + cntT'(push) - cntT'(pop);
			credit <= pop;   // One credit back per pop
		end
	end

	assign head     = mem[rdPtr];
	assign notEmpty = (count != '0);

endmodule

// ==== rtl/pipePkg.sv ====
package pipePkg;
	import isaPkg::*;

	// Packet from the operand-read stage, 128 bits
	typedef struct packed {
		wordT instr;
		addrT pc;
		wordT rsVal;
		wordT rtVal;
	} issueT;

	typedef struct packed {
		aluOpE  aluOp;
		logic   aluSrcImm;   // B operand from the immediate
		logic   extSigned;
		mduOpE  mduOp;
		npcOpE  npcOp;
		resSelE resSel;
		logic   regWrite;
		regIdxT regDst;      // Destination index, already resolved
		logic   illegal;
	} ctrlT;

	// One per instruction, in program order
	typedef struct packed {
		addrT   pc;
		addrT   nextPc;
		logic   regWrite;
		regIdxT wAddr;
		wordT   wData;
		logic   illegal;
	} retireT;

endpackage

// ==== rtl/isaPkg.sv ====
package isaPkg;

	typedef logic [31:0] wordT;
	typedef logic [31:0] addrT;
	typedef logic [4:0]  regIdxT;   // GPR index
	typedef logic [5:0]  opcodeT;
	typedef logic [5:0]  functT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluSltu,
		aluLui
	} aluOpE;

	// Ops that start or write the multiply/divide unit
	typedef enum logic [2:0] {
		mduNone,
		mduMult,
		mduMultu,
		mduDiv,
		mduDivu,
		mduMthi,
		mduMtlo
	} mduOpE;

	typedef enum logic [2:0] {
		npcSeq,
		npcBeq,
		npcBne,
		npcJump,
		npcJr
	} npcOpE;

	typedef enum logic [1:0] {
		resAlu,
		resHi,
		resLo,
		resLink   // jal return address
	} resSelE;

endpackage

// ==== rtl/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

////////////////////
// Opcodes
`define OP_RTYPE 6'b000000
`define OP_ORI   6'b001101
`define OP_ADDI  6'b001000
`define OP_ANDI  6'b001100
`define OP_LUI   6'b001111
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_J     6'b000010
`define OP_JAL   6'b000011

////////////////////
// R-type funct codes
`define FN_ADD   6'b100000
`define FN_SUB   6'b100010
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_SLT   6'b101010
`define FN_SLTU  6'b101011
`define FN_JR    6'b001000
`define FN_MULT  6'b011000
`define FN_MULTU 6'b011001
`define FN_DIV   6'b011010
`define FN_DIVU  6'b011011
`define FN_MFHI  6'b010000
`define FN_MFLO  6'b010010
`define FN_MTHI  6'b010001
`define FN_MTLO  6'b010011

`define IN_CREDITS  4   // Issue queue depth
`define OUT_CREDITS 4   // Retire credits held after reset
`define MULT_CYCLES 5
`define DIV_CYCLES  10

`endif
